// File: all.f
+incdir+include
source/muldiv_pkg.sv
source/sign_adjust.sv
source/mul_unit.sv
source/div_unit.sv
source/muldiv_ctrl.sv
source/mips_muldiv.sv
tb/tb_clock.sv
tb/tb_mips_muldiv.sv

// File: include/muldiv_params.svh
////////////////////
// Multiply/divide parameters
// Word width, iteration count and opcode field width
////////////////////
`ifndef MULDIV_PARAMS_SVH
`define MULDIV_PARAMS_SVH

// Data word, sizes operands and HI/LO
`define MD_XLEN 32

// One iteration step per result bit
`define MD_ITERS `MD_XLEN

// Opcode field
`define MD_OP_W 3

`endif

// File: run.sh
#!/bin/sh
# Compile the multiply/divide testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_mips_muldiv \
    --Mdir obj_dir -o sim_tb_mips_muldiv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_tb_mips_muldiv
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

// File: source/div_unit.sv
////////////////////
// Iterative divider
// Unsigned restoring division, remainder in hi, quotient in lo
////////////////////
`default_nettype none

`include "muldiv_params.svh"

module div_unit import muldiv_pkg::*; (
    input  wire                clk,
    input  wire                rst_i,
    input  wire                start_i,
    input  wire                annul_i,
    input  wire [`MD_XLEN-1:0] a_i,
    input  wire [`MD_XLEN-1:0] b_i,
    output md_pair_t           res_o,
    output logic               ready_o
);

    localparam int CNT_W = $clog2(`MD_ITERS + 1);

    logic [CNT_W-1:0]    cnt_q;
    logic                active_q;
    logic [`MD_XLEN-1:0] divisor_q;
    logic [`MD_XLEN-1:0] rem_q;
    // Dividend bits shift out the top as quotient bits shift in
    logic [`MD_XLEN-1:0] quo_q;
    logic [`MD_XLEN:0]   shifted;
    logic [`MD_XLEN+1:0] diff;
    logic                fits;

    assign shifted = {rem_q, quo_q[`MD_XLEN-1]};
    assign diff    = {1'b0, shifted} - {2'b00, divisor_q};
    assign fits    = ~diff[`MD_XLEN+1];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
            ready_o  <= 1'b0;
        end else begin
            ready_o <= 1'b0;
            if (annul_i) begin
                active_q <= 1'b0;
            end else if (start_i) begin
                active_q <= 1'b1;
                cnt_q    <= CNT_W'(`MD_ITERS);
            end else if (active_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == CNT_W'(1)) begin
                    active_q <= 1'b0;
                    ready_o  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            divisor_q <= b_i;
            rem_q     <= '0;
            quo_q     <= a_i;
        end else if (active_q) begin
            // Restore by keeping the shifted value when the divisor does not fit
            rem_q <= fits ? diff[`MD_XLEN-1:0] : shifted[`MD_XLEN-1:0];
            quo_q <= {quo_q[`MD_XLEN-2:0], fits};
        end
    end

    assign res_o.hi = rem_q;
    assign res_o.lo = quo_q;

endmodule

`default_nettype wire

// File: source/mips_muldiv.sv
////////////////////
// Multiply/divide subsystem
// Sequencer with multiplier, divider and sign handling
////////////////////
`default_nettype none

`include "muldiv_params.svh"

module mips_muldiv import muldiv_pkg::*; (
    input  wire           clk,
    input  wire           rst_i,
    input  wire           req_valid_i,
    input  wire md_req_t  req_i,
    input  wire           flush_i,
    output logic          busy_o,
    output md_pair_t      hilo_o
);

    logic                mul_start;
    logic                div_start;
    logic                annul;
    logic                latch;
    logic                mul_ready;
    logic                div_ready;
    logic [`MD_XLEN-1:0] mag_a;
    logic [`MD_XLEN-1:0] mag_b;
    md_pair_t            raw_mul;
    md_pair_t            raw_div;
    md_pair_t            adj;

    muldiv_ctrl ctrl0 (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .flush_i     (flush_i),
        .mul_start_o (mul_start),
        .div_start_o (div_start),
        .annul_o     (annul),
        .latch_o     (latch),
        .mul_ready_i (mul_ready),
        .div_ready_i (div_ready),
        .adj_i       (adj),
        .busy_o      (busy_o),
        .hilo_o      (hilo_o)
    );

    sign_adjust sign0 (
        .clk       (clk),
        .rst_i     (rst_i),
        .latch_i   (latch),
        .req_i     (req_i),
        .mag_a_o   (mag_a),
        .mag_b_o   (mag_b),
        .raw_mul_i (raw_mul),
        .raw_div_i (raw_div),
        .adj_o     (adj)
    );

    mul_unit mul0 (
        .clk     (clk),
        .rst_i   (rst_i),
        .start_i (mul_start),
        .annul_i (annul),
        .a_i     (mag_a),
        .b_i     (mag_b),
        .res_o   (raw_mul),
        .ready_o (mul_ready)
    );

    div_unit div0 (
        .clk     (clk),
        .rst_i   (rst_i),
        .start_i (div_start),
        .annul_i (annul),
        .a_i     (mag_a),
        .b_i     (mag_b),
        .res_o   (raw_div),
        .ready_o (div_ready)
    );

endmodule

`default_nettype wire

// File: source/mul_unit.sv
////////////////////
// Iterative multiplier
// Unsigned shift-add, one bit per cycle, 64-bit product
////////////////////
`default_nettype none

`include "muldiv_params.svh"

module mul_unit import muldiv_pkg::*; (
    input  wire                clk,
    input  wire                rst_i,
    input  wire                start_i,
    input  wire                annul_i,
    input  wire [`MD_XLEN-1:0] a_i,
    input  wire [`MD_XLEN-1:0] b_i,
    output md_pair_t           res_o,
    output logic               ready_o
);

    localparam int CNT_W = $clog2(`MD_ITERS + 1);

    logic [CNT_W-1:0]      cnt_q;
    logic                  active_q;
    logic [`MD_XLEN-1:0]   mcand_q;
    // Upper half accumulates, lower half shifts the multiplier out
    logic [2*`MD_XLEN-1:0] prod_q;
    logic [`MD_XLEN:0]     sum;

    assign sum = prod_q[0] ? ({1'b0, prod_q[2*`MD_XLEN-1:`MD_XLEN]} + {1'b0, mcand_q})
                           : {1'b0, prod_q[2*`MD_XLEN-1:`MD_XLEN]};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
            ready_o  <= 1'b0;
        end else begin
            ready_o <= 1'b0;
            if (annul_i) begin
                active_q <= 1'b0;
            end else if (start_i) begin
                active_q <= 1'b1;
                cnt_q    <= CNT_W'(`MD_ITERS);
            end else if (active_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == CNT_W'(1)) begin
                    active_q <= 1'b0;
                    ready_o  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            mcand_q <= a_i;
            prod_q  <= {{`MD_XLEN{1'b0}}, b_i};
        end else if (active_q) begin
            prod_q <= {sum, prod_q[`MD_XLEN-1:1]};
        end
    end

    assign res_o.hi = prod_q[2*`MD_XLEN-1:`MD_XLEN];
    assign res_o.lo = prod_q[`MD_XLEN-1:0];

endmodule

`default_nettype wire

// File: source/muldiv_ctrl.sv
////////////////////
// Multiply/divide sequencer
// Accepts requests, starts the units, handles annul
// and owns the HI/LO register pair
////////////////////
`default_nettype none

`include "muldiv_params.svh"

module muldiv_ctrl import muldiv_pkg::*; (
    input  wire           clk,
    input  wire           rst_i,
    input  wire           req_valid_i,
    input  wire md_req_t  req_i,
    input  wire           flush_i,
    output logic          mul_start_o,
    output logic          div_start_o,
    output logic          annul_o,
    output logic          latch_o,
    input  wire           mul_ready_i,
    input  wire           div_ready_i,
    input  wire md_pair_t adj_i,
    output logic          busy_o,
    output md_pair_t      hilo_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_MUL_WAIT,
        S_DIV_WAIT
    } state_e;

    state_e state_q;
    logic   accept;
    logic   go_mul;
    logic   go_div;
    logic   done;

    ////////////////////
    // Request decode
    ////////////////////

    // Requests are only taken while idle
    assign accept = req_valid_i && (state_q == S_IDLE);

    assign go_mul = accept && (req_i.op == MD_MULT || req_i.op == MD_MULTU);

    // Zero divisor leaves HI/LO alone and never starts the divider
    assign go_div = accept && (req_i.op == MD_DIV || req_i.op == MD_DIVU)
                    && (req_i.rt != '0);

    // Sign state is captured with the operands that start a unit
    assign latch_o = go_mul || go_div;

    assign busy_o  = (state_q != S_IDLE);
    assign annul_o = flush_i && busy_o;

    assign done = (state_q == S_MUL_WAIT && mul_ready_i)
               || (state_q == S_DIV_WAIT && div_ready_i);

    ////////////////////
    // Sequencer FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q     <= S_IDLE;
            mul_start_o <= 1'b0;
            div_start_o <= 1'b0;
            hilo_o      <= '0;
        end else begin
            mul_start_o <= go_mul;
            div_start_o <= go_div;
            case (state_q)
                S_IDLE: begin
                    if (go_mul) begin
                        state_q <= S_MUL_WAIT;
                    end else if (go_div) begin
                        state_q <= S_DIV_WAIT;
                    end
                    // Direct register moves
                    if (accept && req_i.op == MD_MTHI) begin
                        hilo_o.hi <= req_i.rs;
                    end
                    if (accept && req_i.op == MD_MTLO) begin
                        hilo_o.lo <= req_i.rs;
                    end
                end
                S_MUL_WAIT, S_DIV_WAIT: begin
                    // Annul wins over a ready in the same cycle
                    if (flush_i) begin
                        state_q <= S_IDLE;
                    end else if (done) begin
                        hilo_o  <= adj_i;
                        state_q <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/muldiv_pkg.sv
////////////////////
// Multiply/divide types
// Operation codes, request and HI/LO pair structs
////////////////////
`default_nettype none

`include "muldiv_params.svh"

package muldiv_pkg;

    // Operations accepted by the unit
    typedef enum logic [`MD_OP_W-1:0] {
        MD_MULT  = 3'd0,
        MD_MULTU = 3'd1,
        MD_DIV   = 3'd2,
        MD_DIVU  = 3'd3,
        MD_MTHI  = 3'd4,
        MD_MTLO  = 3'd5
    } md_op_e;

    // Request from the execute stage
    typedef struct packed {
        md_op_e              op;
        logic [`MD_XLEN-1:0] rs;
        logic [`MD_XLEN-1:0] rt;
    } md_req_t;

    // HI/LO pair, also used for raw and adjusted unit results
    typedef struct packed {
        logic [`MD_XLEN-1:0] hi;
        logic [`MD_XLEN-1:0] lo;
    } md_pair_t;

endpackage

`default_nettype wire

// File: source/sign_adjust.sv
////////////////////
// Sign handling
// Operand magnitudes in, signed results out
////////////////////
`default_nettype none

`include "muldiv_params.svh"

module sign_adjust import muldiv_pkg::*; (
    input  wire                 clk,
    input  wire                 rst_i,
    input  wire                 latch_i,
    input  wire md_req_t        req_i,
    output logic [`MD_XLEN-1:0] mag_a_o,
    output logic [`MD_XLEN-1:0] mag_b_o,
    input  wire md_pair_t       raw_mul_i,
    input  wire md_pair_t       raw_div_i,
    output md_pair_t            adj_o
);

    logic                  is_signed;
    logic                  neg_a_q;
    logic                  neg_b_q;
    logic                  is_div_q;
    logic [2*`MD_XLEN-1:0] prod;

    assign is_signed = (req_i.op == MD_MULT) || (req_i.op == MD_DIV);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            neg_a_q  <= 1'b0;
            neg_b_q  <= 1'b0;
            is_div_q <= 1'b0;
        end else if (latch_i) begin
            neg_a_q  <= is_signed && req_i.rs[`MD_XLEN-1];
            neg_b_q  <= is_signed && req_i.rt[`MD_XLEN-1];
            is_div_q <= (req_i.op == MD_DIV) || (req_i.op == MD_DIVU);
        end
    end

    always_ff @(posedge clk) begin
        if (latch_i) begin
            mag_a_o <= (is_signed && req_i.rs[`MD_XLEN-1]) ? -req_i.rs : req_i.rs;
            mag_b_o <= (is_signed && req_i.rt[`MD_XLEN-1]) ? -req_i.rt : req_i.rt;
        end
    end

    assign prod = (neg_a_q ^ neg_b_q) ? -{raw_mul_i.hi, raw_mul_i.lo}
                                      : {raw_mul_i.hi, raw_mul_i.lo};

    // Remainder follows the dividend, quotient follows the sign product
    always_comb begin
        if (is_div_q) begin
            adj_o.hi = neg_a_q ? -raw_div_i.hi : raw_div_i.hi;
            adj_o.lo = (neg_a_q ^ neg_b_q) ? -raw_div_i.lo : raw_div_i.lo;
        end else begin
            adj_o.hi = prod[2*`MD_XLEN-1:`MD_XLEN];
            adj_o.lo = prod[`MD_XLEN-1:0];
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
////////////////////
// Testbench clock
// Free running clock, period of 4 time units
////////////////////
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD = 2
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #HALF_PERIOD clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: tb/tb_mips_muldiv.sv
////////////////////
// Multiply/divide testbench
// Random and corner MULT/DIV traffic, HI/LO moves and
// flush checks against an arithmetic reference
////////////////////
`default_nettype none

`include "muldiv_params.svh"

module tb_mips_muldiv import muldiv_pkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int MOVE_OPS     = 8;
    localparam int MUL_OPS      = 50;
    localparam int DIV_OPS      = 50;
    localparam int FLUSH_OPS    = 5;
    localparam int N_OPS        = MOVE_OPS + MUL_OPS + DIV_OPS + FLUSH_OPS;
    localparam int CYCLE_LIMIT  = 40 * N_OPS + RESET_CYCLES;
    // Start cycle, one cycle per iteration, write cycle
    localparam int OP_LATENCY   = `MD_ITERS + 2;

    logic     clk;
    logic     rst_i;
    logic     req_valid_i;
    md_req_t  req_i;
    logic     flush_i;
    logic     busy_o;
    md_pair_t hilo_o;

    md_pair_t model;
    md_pair_t exp_q[$];
    int       seed;
    int       cycle_cnt = 0;

    logic [`MD_XLEN-1:0] corners [5] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                                         32'h8000_0000, 32'h7fff_ffff};

    tb_clock clk_gen (
        .clk_o (clk)
    );

    mips_muldiv dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .flush_i     (flush_i),
        .busy_o      (busy_o),
        .hilo_o      (hilo_o)
    );

    ////////////////////
    // Reference and checks
    ////////////////////

    // Expected HI/LO from plain arithmetic on the sign extended words
    function automatic md_pair_t ref_muldiv(md_op_e op, logic [`MD_XLEN-1:0] a,
                                            logic [`MD_XLEN-1:0] b, md_pair_t old);
        md_pair_t                     res;
        logic signed [2*`MD_XLEN-1:0] sa;
        logic signed [2*`MD_XLEN-1:0] sb;
        logic signed [2*`MD_XLEN-1:0] sr;
        logic [2*`MD_XLEN-1:0]        ur;
        res = old;
        sa  = {{`MD_XLEN{a[`MD_XLEN-1]}}, a};
        sb  = {{`MD_XLEN{b[`MD_XLEN-1]}}, b};
        case (op)
            MD_MULT: begin
                sr     = sa * sb;
                res.hi = sr[2*`MD_XLEN-1:`MD_XLEN];
                res.lo = sr[`MD_XLEN-1:0];
            end
            MD_MULTU: begin
                ur     = {{`MD_XLEN{1'b0}}, a} * {{`MD_XLEN{1'b0}}, b};
                res.hi = ur[2*`MD_XLEN-1:`MD_XLEN];
                res.lo = ur[`MD_XLEN-1:0];
            end
            MD_DIV: begin
                if (b != '0) begin
                    sr     = sa % sb;
                    res.hi = sr[`MD_XLEN-1:0];
                    sr     = sa / sb;
                    res.lo = sr[`MD_XLEN-1:0];
                end
            end
            MD_DIVU: begin
                if (b != '0) begin
                    res.hi = a % b;
                    res.lo = a / b;
                end
            end
            MD_MTHI: res.hi = a;
            MD_MTLO: res.lo = a;
            default: res = old;
        endcase
        return res;
    endfunction

    task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // Expected pairs are compared with the HI/LO value held before this edge
    always @(posedge clk) begin
        md_pair_t e;
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            check_val("hilo_o.hi", 64'(hilo_o.hi), 64'(e.hi));
            check_val("hilo_o.lo", 64'(hilo_o.lo), 64'(e.lo));
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: busy never fell");
            $display(">>> FAIL");
            $fatal(1, "cycle limit of %0d reached", CYCLE_LIMIT);
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic send_req(md_op_e op, logic [`MD_XLEN-1:0] a, logic [`MD_XLEN-1:0] b);
        req_i.op    = op;
        req_i.rs    = a;
        req_i.rt    = b;
        req_valid_i = 1'b1;
        @(negedge clk);
        req_valid_i = 1'b0;
    endtask

    task automatic run_op(md_op_e op, logic [`MD_XLEN-1:0] a, logic [`MD_XLEN-1:0] b);
        md_pair_t exp;
        logic     is_mul;
        logic     is_div;
        int       lat;
        exp    = ref_muldiv(op, a, b, model);
        is_mul = (op == MD_MULT) || (op == MD_MULTU);
        is_div = ((op == MD_DIV) || (op == MD_DIVU)) && (b != '0);
        send_req(op, a, b);
        if (is_mul || is_div) begin
            check_val("busy_o", 64'(busy_o), 64'd1);
            lat = 0;
            while (busy_o) begin
                @(negedge clk);
                lat++;
            end
            check_val("busy_o latency", 64'(lat), 64'(OP_LATENCY));
        end else begin
            // Moves and zero divisor never stall
            check_val("busy_o", 64'(busy_o), 64'd0);
        end
        model = exp;
        exp_q.push_back(exp);
    endtask

    task automatic run_flush(md_op_e op, logic [`MD_XLEN-1:0] a, logic [`MD_XLEN-1:0] b,
                             int delay);
        send_req(op, a, b);
        check_val("busy_o", 64'(busy_o), 64'd1);
        repeat (delay) @(negedge clk);
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
        check_val("busy_o", 64'(busy_o), 64'd0);
        exp_q.push_back(model);
    endtask

    initial begin
        logic [`MD_XLEN-1:0] a;
        logic [`MD_XLEN-1:0] b;
        md_op_e              op;
        int                  i;
        seed        = 32'h60e5_af22;
        model       = '0;
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        flush_i     = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        check_val("busy_o", 64'(busy_o), 64'd0);
        exp_q.push_back(model);
        @(negedge clk);

        for (i = 0; i < MOVE_OPS; i++) begin
            op = (i % 2 == 1) ? MD_MTLO : MD_MTHI;
            a  = $random(seed);
            run_op(op, a, '0);
        end

        for (i = 0; i < MUL_OPS; i++) begin
            op = (i % 2 == 1) ? MD_MULTU : MD_MULT;
            if (i < 10) begin
                a = corners[i % 5];
                b = corners[(i + 2) % 5];
            end else begin
                a = $random(seed);
                b = $random(seed);
            end
            run_op(op, a, b);
        end

        for (i = 0; i < DIV_OPS; i++) begin
            op = (i % 2 == 1) ? MD_DIVU : MD_DIV;
            a  = $random(seed);
            b  = $random(seed);
            // Smaller divisors give nonzero quotients
            b  = b >> (i % 24);
            if (i % 4 == 2) begin
                b = -b;
            end
            // Zero divisor on both DIV and DIVU
            if (i % 5 == 3) begin
                b = '0;
            end
            if (i == 0) begin
                a = 32'h8000_0000;
                b = 32'hffff_ffff;
            end
            run_op(op, a, b);
        end

        run_flush(MD_MULT, $random(seed), $random(seed), 0);
        run_flush(MD_DIVU, $random(seed), 32'd7, 12);
        run_flush(MD_DIV, $random(seed), 32'hffff_fff3, 20);
        run_flush(MD_MULTU, $random(seed), $random(seed), 33);
        // Unit still usable after an annul
        run_op(MD_MULT, $random(seed), $random(seed));

        repeat (2) @(negedge clk);
        if (exp_q.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("expected HI/LO values were left unchecked");
            $display(">>> FAIL");
            $fatal(1, "compare queue not empty");
        end
    end

endmodule

`default_nettype wire
